// ==== rv32i_types_pkg.sv ====
`default_nettype none

package rv32i_types_pkg;

	// pc and instruction word width
	localparam int WORD_W = 32;
	// register index and opcode field widths
	localparam int REG_W = 5;
	localparam int OPCODE_W = 7;

	// field positions in the base encoding
	localparam int RD_LSB = 7;
	localparam int RS1_LSB = 15;

	// sequential fetch step, all words are 32-bit
	localparam logic [WORD_W-1:0] PC_STEP = 32'd4;

	// only the two jump opcodes are of interest
	typedef enum logic [OPCODE_W-1:0] {
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		OTHER = 7'b0000000
	} opcode_t;

	// ra and t0, the link registers of the hint table
	localparam logic [REG_W-1:0] LINK_A = 5'd1;
	localparam logic [REG_W-1:0] LINK_B = 5'd5;

	// anything that is not a jump folds into OTHER
	function automatic opcode_t decode_opcode(input logic [WORD_W-1:0] instr);
		case (instr[OPCODE_W-1:0])
			JAL:     return JAL;
			JALR:    return JALR;
			default: return OTHER;
		endcase
	endfunction

	function automatic logic [REG_W-1:0] get_rd(input logic [WORD_W-1:0] instr);
		return instr[RD_LSB +: REG_W];
	endfunction

	function automatic logic [REG_W-1:0] get_rs1(input logic [WORD_W-1:0] instr);
		return instr[RS1_LSB +: REG_W];
	endfunction

	function automatic logic is_link(input logic [REG_W-1:0] r);
		return (r == LINK_A) || (r == LINK_B);
	endfunction

endpackage

`default_nettype wire

// ==== ras_pkg.sv ====
`default_nettype none

package ras_pkg;

	// what the return stack does with one item
	// pop-then-push is the coroutine swap case
	typedef enum logic [1:0] {
		RAS_NONE     = 2'b00,
		RAS_PUSH     = 2'b01,
		RAS_POP      = 2'b10,
		RAS_POP_PUSH = 2'b11
	} ras_action_t;

	// kind of jump, carried down to the target select
	typedef enum logic [1:0] {
		JK_NONE = 2'b00,
		JK_JAL  = 2'b01,
		JK_JALR = 2'b10
	} jump_kind_t;

endpackage

`default_nettype wire

// ==== link_classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module link_classifier (
	input  wire                                 CLK,
	input  wire                                 nRST,
	// fetch side
	input  wire                                 in_valid,
	output logic                                in_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   in_pc,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   in_instr,
	// towards the return stack
	output logic                                s1_valid,
	input  wire                                 s1_ready,
	output logic [rv32i_types_pkg::WORD_W-1:0]  s1_pc,
	output ras_pkg::ras_action_t                s1_action,
	output ras_pkg::jump_kind_t                 s1_kind,
	output logic [rv32i_types_pkg::WORD_W-1:0]  s1_imm
);
	import rv32i_types_pkg::*;
	import ras_pkg::*;

	opcode_t                 op;
	logic [REG_W-1:0]        rd;
	logic [REG_W-1:0]        rs1;
	logic                    rd_link;
	logic                    rs1_link;
	logic [WORD_W-1:0]       j_imm;
	ras_action_t             action_c;
	jump_kind_t              kind_c;
	logic                    accept;

	// field decode
	assign op       = decode_opcode(in_instr);
	assign rd       = get_rd(in_instr);
	assign rs1      = get_rs1(in_instr);
	assign rd_link  = is_link(rd);
	assign rs1_link = is_link(rs1);

	// J-type immediate, bit 0 always zero
	assign j_imm = {{(WORD_W-20){in_instr[31]}}, in_instr[19:12], in_instr[20],
		in_instr[30:21], 1'b0};

	// hint table
	always_comb begin
		action_c = RAS_NONE;
		kind_c   = JK_NONE;
		case (op)
			JAL: begin
				kind_c = JK_JAL;
				// call only when the link lands in ra or t0
				if (rd_link) begin
					action_c = RAS_PUSH;
				end
			end
			JALR: begin
				kind_c = JK_JALR;
				case ({rd_link, rs1_link})
					2'b10: action_c = RAS_PUSH;
					2'b01: action_c = RAS_POP;
					// both link, same reg is a plain call
					2'b11: action_c = (rd == rs1) ? RAS_PUSH : RAS_POP_PUSH;
					default: action_c = RAS_NONE;
				endcase
			end
			default: begin
				action_c = RAS_NONE;
				kind_c   = JK_NONE;
			end
		endcase
	end

	// slot free or draining this cycle
	assign in_ready = !s1_valid || s1_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			s1_valid <= 1'b0;
		end else if (accept) begin
			s1_valid <= 1'b1;
		end else if (s1_ready) begin
			s1_valid <= 1'b0;
		end
	end

	// payload only moves on acceptance
	always_ff @(posedge CLK) begin
		if (accept) begin
			s1_pc     <= in_pc;
			s1_action <= action_c;
			s1_kind   <= kind_c;
			s1_imm    <= j_imm;
		end
	end

endmodule

`default_nettype wire

// ==== return_stack.sv ====
`timescale 1ns/1ns
`default_nettype none

module return_stack #(
	parameter int RAS_DEPTH = 4
) (
	input  wire                                 CLK,
	input  wire                                 nRST,
	// from the classifier
	input  wire                                 s1_valid,
	output logic                                s1_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   s1_pc,
	input  wire ras_pkg::ras_action_t           s1_action,
	input  wire ras_pkg::jump_kind_t            s1_kind,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   s1_imm,
	// towards target select
	output logic                                s2_valid,
	input  wire                                 s2_ready,
	output logic [rv32i_types_pkg::WORD_W-1:0]  s2_pc,
	output ras_pkg::jump_kind_t                 s2_kind,
	output logic [rv32i_types_pkg::WORD_W-1:0]  s2_imm,
	output logic                                s2_pop_hit,
	output logic [rv32i_types_pkg::WORD_W-1:0]  s2_pop_addr
);
	import rv32i_types_pkg::*;
	import ras_pkg::*;

	// pointer wraps for free since depth is a power of two
	localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
	localparam int CNT_W = $clog2(RAS_DEPTH + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(RAS_DEPTH);

	logic [WORD_W-1:0]  ras [RAS_DEPTH];
	logic [PTR_W-1:0]   ptr;
	logic [CNT_W-1:0]   count;

	logic               accept;
	logic [WORD_W-1:0]  link_addr;
	logic [PTR_W-1:0]   top_idx;
	logic               not_empty;
	logic               wr_en;
	logic [PTR_W-1:0]   wr_idx;
	logic [PTR_W-1:0]   ptr_nxt;
	logic [CNT_W-1:0]   cnt_nxt;
	logic               hit_c;
	logic [WORD_W-1:0]  pop_addr_c;

	assign s1_ready  = !s2_valid || s2_ready;
	assign accept    = s1_valid && s1_ready;
	// return address of the call
	assign link_addr = s1_pc + PC_STEP;
	// newest entry sits just below the pointer
	assign top_idx   = ptr - 1'b1;
	assign not_empty = (count != '0);

	always_comb begin
		wr_en      = 1'b0;
		wr_idx     = ptr;
		ptr_nxt    = ptr;
		cnt_nxt    = count;
		hit_c      = 1'b0;
		pop_addr_c = '0;
		if (accept) begin
			case (s1_action)
				RAS_PUSH: begin
					wr_en   = 1'b1;
					ptr_nxt = ptr + 1'b1;
					// full stack drops the oldest entry
					if (count != CNT_FULL) begin
						cnt_nxt = count + 1'b1;
					end
				end
				RAS_POP: begin
					if (not_empty) begin
						hit_c      = 1'b1;
						pop_addr_c = ras[top_idx];
						ptr_nxt    = top_idx;
						cnt_nxt    = count - 1'b1;
					end
				end
				RAS_POP_PUSH: begin
					wr_en = 1'b1;
					if (not_empty) begin
						// swap in place, pointer stays
						hit_c      = 1'b1;
						pop_addr_c = ras[top_idx];
						wr_idx     = top_idx;
					end else begin
						// empty, degrade to a push
						ptr_nxt = ptr + 1'b1;
						cnt_nxt = count + 1'b1;
					end
				end
				default: begin
					wr_en = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr      <= '0;
			count    <= '0;
			s2_valid <= 1'b0;
		end else begin
			ptr   <= ptr_nxt;
			count <= cnt_nxt;
			if (accept) begin
				s2_valid <= 1'b1;
			end else if (s2_ready) begin
				s2_valid <= 1'b0;
			end
		end
	end

	// entry storage
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			ras[wr_idx] <= link_addr;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			s2_pc       <= s1_pc;
			s2_kind     <= s1_kind;
			s2_imm      <= s1_imm;
			s2_pop_hit  <= hit_c;
			s2_pop_addr <= pop_addr_c;
		end
	end

endmodule

`default_nettype wire

// ==== next_pc_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module next_pc_select (
	input  wire                                 CLK,
	input  wire                                 nRST,
	// from the return stack
	input  wire                                 s2_valid,
	output logic                                s2_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   s2_pc,
	input  wire ras_pkg::jump_kind_t            s2_kind,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   s2_imm,
	input  wire                                 s2_pop_hit,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   s2_pop_addr,
	// prediction out
	output logic                                out_valid,
	input  wire                                 out_ready,
	output logic [rv32i_types_pkg::WORD_W-1:0]  out_pc,
	output logic                                out_taken,
	output logic [rv32i_types_pkg::WORD_W-1:0]  out_target
);
	import rv32i_types_pkg::*;
	import ras_pkg::*;

	logic               accept;
	logic [WORD_W-1:0]  jal_target;
	logic [WORD_W-1:0]  seq_target;
	logic               taken_c;
	logic [WORD_W-1:0]  target_c;

	// direct target and fall-through
	assign jal_target = s2_pc + s2_imm;
	assign seq_target = s2_pc + PC_STEP;

	always_comb begin
		taken_c  = 1'b0;
		target_c = seq_target;
		case (s2_kind)
			JK_JAL: begin
				taken_c  = 1'b1;
				target_c = jal_target;
			end
			JK_JALR: begin
				// indirect jump only predicted from the stack
				if (s2_pop_hit) begin
					taken_c  = 1'b1;
					target_c = s2_pop_addr;
				end
			end
			default: begin
				taken_c  = 1'b0;
				target_c = seq_target;
			end
		endcase
	end

	assign s2_ready = !out_valid || out_ready;
	assign accept   = s2_valid && s2_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// held while out_ready is low
	always_ff @(posedge CLK) begin
		if (accept) begin
			out_pc     <= s2_pc;
			out_taken  <= taken_c;
			out_target <= target_c;
		end
	end

endmodule

`default_nettype wire

// ==== return_predictor_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module return_predictor_top #(
	parameter int RAS_DEPTH = 4
) (
	input  wire                                 CLK,
	input  wire                                 nRST,
	input  wire                                 in_valid,
	output logic                                in_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   in_pc,
	input  wire [rv32i_types_pkg::WORD_W-1:0]   in_instr,
	output logic                                out_valid,
	input  wire                                 out_ready,
	output logic [rv32i_types_pkg::WORD_W-1:0]  out_pc,
	output logic                                out_taken,
	output logic [rv32i_types_pkg::WORD_W-1:0]  out_target
);
	import rv32i_types_pkg::*;
	import ras_pkg::*;

	// classifier to stack
	logic               s1_valid;
	logic               s1_ready;
	logic [WORD_W-1:0]  s1_pc;
	ras_action_t        s1_action;
	jump_kind_t         s1_kind;
	logic [WORD_W-1:0]  s1_imm;

	// stack to target select
	logic               s2_valid;
	logic               s2_ready;
	logic [WORD_W-1:0]  s2_pc;
	jump_kind_t         s2_kind;
	logic [WORD_W-1:0]  s2_imm;
	logic               s2_pop_hit;
	logic [WORD_W-1:0]  s2_pop_addr;

	// stage 1, jump decode
	link_classifier u_classifier (
		.CLK       (CLK),
		.nRST      (nRST),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pc     (in_pc),
		.in_instr  (in_instr),
		.s1_valid  (s1_valid),
		.s1_ready  (s1_ready),
		.s1_pc     (s1_pc),
		.s1_action (s1_action),
		.s1_kind   (s1_kind),
		.s1_imm    (s1_imm)
	);

	// stage 2, updated in program order
	return_stack #(
		.RAS_DEPTH (RAS_DEPTH)
	) u_stack (
		.CLK         (CLK),
		.nRST        (nRST),
		.s1_valid    (s1_valid),
		.s1_ready    (s1_ready),
		.s1_pc       (s1_pc),
		.s1_action   (s1_action),
		.s1_kind     (s1_kind),
		.s1_imm      (s1_imm),
		.s2_valid    (s2_valid),
		.s2_ready    (s2_ready),
		.s2_pc       (s2_pc),
		.s2_kind     (s2_kind),
		.s2_imm      (s2_imm),
		.s2_pop_hit  (s2_pop_hit),
		.s2_pop_addr (s2_pop_addr)
	);

	// stage 3, target mux
	next_pc_select u_select (
		.CLK         (CLK),
		.nRST        (nRST),
		.s2_valid    (s2_valid),
		.s2_ready    (s2_ready),
		.s2_pc       (s2_pc),
		.s2_kind     (s2_kind),
		.s2_imm      (s2_imm),
		.s2_pop_hit  (s2_pop_hit),
		.s2_pop_addr (s2_pop_addr),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_pc      (out_pc),
		.out_taken   (out_taken),
		.out_target  (out_target)
	);

endmodule

`default_nettype wire

// ==== return_predictor_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module return_predictor_sva (
	input wire                                CLK,
	input wire                                nRST,
	input wire                                in_ready,
	input wire                                out_valid,
	input wire                                out_ready,
	input wire [rv32i_types_pkg::WORD_W-1:0]  out_pc,
	input wire                                out_taken,
	input wire [rv32i_types_pkg::WORD_W-1:0]  out_target
);
	int fail_count = 0;

	// second edge of reset, flops cleared by then
	reset_clears_valid: assert property (@(posedge CLK)
		(!nRST && !$past(nRST)) |-> !out_valid)
		else begin
			$error("out_valid high while reset is held");
			fail_count++;
		end

	valid_holds: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && !out_ready) |=> out_valid)
		else begin
			$error("out_valid dropped before the output was taken");
			fail_count++;
		end

	data_holds: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && !out_ready) |=>
		($stable(out_pc) && $stable(out_taken) && $stable(out_target)))
		else begin
			$error("output data changed while stalled");
			fail_count++;
		end

	// ready chain is combinational end to end
	ready_chain: assert property (@(posedge CLK) disable iff (!nRST)
		out_ready |-> in_ready)
		else begin
			$error("in_ready low although out_ready is high");
			fail_count++;
		end

endmodule

bind return_predictor_top return_predictor_sva u_sva (
	.CLK        (CLK),
	.nRST       (nRST),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_pc     (out_pc),
	.out_taken  (out_taken),
	.out_target (out_target)
);

`default_nettype wire

// ==== return_predictor_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module return_predictor_checker #(
	parameter int RAS_DEPTH = 4
) (
	input  wire                                CLK,
	input  wire                                nRST,
	input  wire                                in_valid,
	input  wire                                in_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]  in_pc,
	input  wire [rv32i_types_pkg::WORD_W-1:0]  in_instr,
	input  wire                                out_valid,
	input  wire                                out_ready,
	input  wire [rv32i_types_pkg::WORD_W-1:0]  out_pc,
	input  wire                                out_taken,
	input  wire [rv32i_types_pkg::WORD_W-1:0]  out_target,
	input  wire                                check_latency,
	output int                                 mismatch_count,
	output int                                 other_count,
	output int                                 in_count,
	output int                                 out_count
);
	import rv32i_types_pkg::*;

	localparam int LATENCY = 3;

	// newest return address at the back
	logic [WORD_W-1:0]  ras_model [$];
	// expected results in program order
	logic [WORD_W-1:0]  exp_pc [$];
	logic               exp_taken [$];
	logic [WORD_W-1:0]  exp_target [$];
	int                 exp_cycle [$];
	logic               exp_timed [$];
	int                 cycle;

	// hint table, stack and target rules applied to the model
	function automatic void predict(input logic [WORD_W-1:0] pc,
		input logic [WORD_W-1:0] instr, output logic taken, output logic [WORD_W-1:0] target);
		logic [6:0]         opc;
		logic [4:0]         rd;
		logic [4:0]         rs1;
		logic               rd_l;
		logic               rs1_l;
		logic               do_pop;
		logic               do_push;
		logic               hit;
		logic [WORD_W-1:0]  imm;
		logic [WORD_W-1:0]  popped;
		logic [WORD_W-1:0]  link;
		opc     = instr[6:0];
		rd      = instr[11:7];
		rs1     = instr[19:15];
		rd_l    = (rd == 5'd1) || (rd == 5'd5);
		rs1_l   = (rs1 == 5'd1) || (rs1 == 5'd5);
		imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		link    = pc + 32'd4;
		do_pop  = 1'b0;
		do_push = 1'b0;
		hit     = 1'b0;
		popped  = '0;
		if (opc == JAL) begin
			do_push = rd_l;
		end else if (opc == JALR) begin
			if (rd_l && !rs1_l) begin
				do_push = 1'b1;
			end else if (!rd_l && rs1_l) begin
				do_pop = 1'b1;
			end else if (rd_l && rs1_l) begin
				// swap unless both name the same reg
				do_pop  = (rd != rs1);
				do_push = 1'b1;
			end
		end
		if (do_pop && ras_model.size() > 0) begin
			hit    = 1'b1;
			popped = ras_model.pop_back();
		end
		if (do_push) begin
			ras_model.push_back(link);
			// oldest entry is lost when full
			if (ras_model.size() > RAS_DEPTH) begin
				ras_model.delete(0);
			end
		end
		if (opc == JAL) begin
			taken  = 1'b1;
			target = pc + imm;
		end else if (opc == JALR && hit) begin
			taken  = 1'b1;
			target = popped;
		end else begin
			taken  = 1'b0;
			target = link;
		end
	endfunction

	task automatic compare_field(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h expected %h", name, got, exp);
			mismatch_count++;
		end
	endtask

	// handshakes sampled mid-cycle, they commit on the next rising edge
	always @(negedge CLK) begin
		logic               taken_e;
		logic [WORD_W-1:0]  target_e;
		logic [WORD_W-1:0]  pc_e;
		int                 born;
		logic               timed;
		if (!nRST) begin
			cycle          = 0;
			mismatch_count = 0;
			other_count    = 0;
			in_count       = 0;
			out_count      = 0;
			ras_model.delete();
			exp_pc.delete();
			exp_taken.delete();
			exp_target.delete();
			exp_cycle.delete();
			exp_timed.delete();
		end else begin
			cycle++;
			if (in_valid && in_ready) begin
				predict(in_pc, in_instr, taken_e, target_e);
				exp_pc.push_back(in_pc);
				exp_taken.push_back(taken_e);
				exp_target.push_back(target_e);
				exp_cycle.push_back(cycle);
				exp_timed.push_back(check_latency);
				in_count++;
			end
			if (out_valid && out_ready) begin
				out_count++;
				if (exp_pc.size() == 0) begin
					$display("output at pc %h appeared with no input waiting for it", out_pc);
					other_count++;
				end else begin
					pc_e     = exp_pc.pop_front();
					taken_e  = exp_taken.pop_front();
					target_e = exp_target.pop_front();
					born     = exp_cycle.pop_front();
					timed    = exp_timed.pop_front();
					compare_field("out_pc", out_pc, pc_e);
					compare_field("out_taken", 32'(out_taken), 32'(taken_e));
					compare_field("out_target", out_target, target_e);
					if (timed && (cycle - born) != LATENCY) begin
						$display("item at pc %h came out %0d cycles after input, not %0d",
							pc_e, cycle - born, LATENCY);
						other_count++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_return_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_return_predictor;
	import rv32i_types_pkg::*;

	localparam int RAS_DEPTH = 4;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int RANDOM_ITEMS = 300;
	// base opcodes used to build stimulus words
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	logic               CLK = 1'b0;
	logic               nRST;
	logic               in_valid;
	logic               in_ready;
	logic [WORD_W-1:0]  in_pc;
	logic [WORD_W-1:0]  in_instr;
	logic               out_valid;
	logic               out_ready;
	logic [WORD_W-1:0]  out_pc;
	logic               out_taken;
	logic [WORD_W-1:0]  out_target;

	logic               check_latency;
	logic               random_ready;
	logic [31:0]        lcg_state;
	logic [WORD_W-1:0]  pc;
	int                 sent;
	int                 mismatch_count;
	int                 other_count;
	int                 in_count;
	int                 out_count;

	always #20 CLK = ~CLK;

	return_predictor_top #(
		.RAS_DEPTH (RAS_DEPTH)
	) u_dut (
		.CLK        (CLK),
		.nRST       (nRST),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_pc      (in_pc),
		.in_instr   (in_instr),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_pc     (out_pc),
		.out_taken  (out_taken),
		.out_target (out_target)
	);

	return_predictor_checker #(
		.RAS_DEPTH (RAS_DEPTH)
	) u_checker (
		.CLK            (CLK),
		.nRST           (nRST),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_pc          (in_pc),
		.in_instr       (in_instr),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_pc         (out_pc),
		.out_taken      (out_taken),
		.out_target     (out_target),
		.check_latency  (check_latency),
		.mismatch_count (mismatch_count),
		.other_count    (other_count),
		.in_count       (in_count),
		.out_count      (out_count)
	);

	// numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// J-type, offset bit 0 dropped by the encoding
	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OPC_JALR};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$finish;
	endtask

	// one clock, inputs change 2 ns after the edge
	task automatic step_cycle();
		@(posedge CLK);
		#2;
		if (random_ready) begin
			lcg_state = lcg_next(lcg_state);
			// low about one cycle in four
			out_ready = (lcg_state[31:30] != 2'b00);
		end
	endtask

	// hold the word until in_ready was seen high before an edge
	task automatic send_item(input logic [31:0] instr);
		logic accepted;
		int   waited;
		in_valid = 1'b1;
		in_pc    = pc;
		in_instr = instr;
		accepted = 1'b0;
		waited   = 0;
		while (!accepted && waited < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			accepted = in_ready;
			step_cycle();
			waited++;
		end
		in_valid = 1'b0;
		if (!accepted) begin
			abort_run("timeout: in_ready stayed low while an item was offered");
		end else begin
			pc = pc + 32'd4;
			sent++;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (out_count != in_count && waited < TIMEOUT_CYCLES) begin
			step_cycle();
			waited++;
		end
		if (out_count != in_count) begin
			abort_run("timeout: pipeline did not drain");
		end
	endtask

	// random mix of calls, returns, swaps and plain words
	task automatic pick_instr(output logic [31:0] w);
		logic [20:0] joff;
		lcg_state = lcg_next(lcg_state);
		joff = {{9{lcg_state[27]}}, lcg_state[27:17], 1'b0};
		case (lcg_state[30:28])
			3'd0: w = jal_word(5'd1, joff);
			3'd1: w = jalr_word(5'd5, 5'd12, 12'h010);
			3'd2: w = jalr_word(5'd0, 5'd1, 12'h000);
			3'd3: w = jalr_word(5'd0, 5'd5, 12'h000);
			3'd4: w = jalr_word(5'd1, 5'd5, 12'h000);
			3'd5: w = jal_word(5'd0, joff);
			3'd6: w = jalr_word(5'd0, 5'd10, 12'h020);
			default: w = addi_word(5'd7, 5'd7, lcg_state[11:0]);
		endcase
	endtask

	// hard limit on simulated time
	initial begin
		#1000000;
		abort_run("timeout: simulation ran past its time limit");
	end

	initial begin
		int          i;
		int          gap;
		logic [31:0] w;
		nRST          = 1'b0;
		in_valid      = 1'b0;
		in_pc         = '0;
		in_instr      = '0;
		out_ready     = 1'b1;
		check_latency = 1'b0;
		random_ready  = 1'b0;
		lcg_state     = 32'haf33;
		pc            = 32'h0000_1000;
		sent          = 0;
		repeat (2) @(posedge CLK);
		#2;
		nRST = 1'b1;
		step_cycle();

		// nested calls by jal and jalr, then returns
		send_item(jal_word(5'd1, 21'h000100));
		send_item(jalr_word(5'd5, 5'd10, 12'h040));
		send_item(jal_word(5'd5, 21'h1ffff0));
		send_item(jalr_word(5'd0, 5'd5, 12'h000));
		send_item(jalr_word(5'd0, 5'd1, 12'h000));
		send_item(jalr_word(5'd0, 5'd1, 12'h000));

		// overflow, then returns past the bottom
		for (i = 0; i < RAS_DEPTH + 2; i++) begin
			send_item(jal_word(5'd1, 21'h000080));
		end
		for (i = 0; i < RAS_DEPTH + 3; i++) begin
			send_item(jalr_word(5'd0, 5'd1, 12'h000));
		end

		// swap on an empty stack acts as a push
		send_item(jalr_word(5'd1, 5'd5, 12'h000));
		send_item(jalr_word(5'd5, 5'd1, 12'h000));
		// same link reg on both sides is a call
		send_item(jalr_word(5'd1, 5'd1, 12'h000));
		send_item(jalr_word(5'd5, 5'd5, 12'h000));
		send_item(jalr_word(5'd1, 5'd5, 12'h000));
		for (i = 0; i < 4; i++) begin
			send_item(jalr_word(5'd0, 5'd1, 12'h000));
		end

		// no stack action
		send_item(jal_word(5'd0, 21'h1fff00));
		send_item(jal_word(5'd3, 21'h000ffc));
		send_item(jalr_word(5'd0, 5'd10, 12'h010));
		send_item(jalr_word(5'd10, 5'd11, 12'h000));
		send_item(addi_word(5'd1, 5'd1, 12'h004));
		wait_drain();

		// back to back with out_ready high
		check_latency = 1'b1;
		for (i = 0; i < 8; i++) begin
			send_item((i % 2 == 0) ? jal_word(5'd1, 21'h000040) : addi_word(5'd2, 5'd2, 12'h001));
		end
		wait_drain();
		check_latency = 1'b0;

		// random back-pressure and input gaps
		random_ready = 1'b1;
		for (i = 0; i < RANDOM_ITEMS; i++) begin
			pick_instr(w);
			send_item(w);
			lcg_state = lcg_next(lcg_state);
			gap = (lcg_state[31:30] == 2'b00) ? int'(lcg_state[29:28]) + 1 : 0;
			repeat (gap) step_cycle();
		end
		random_ready = 1'b0;
		out_ready    = 1'b1;
		wait_drain();

		$display("errors: %0d value, %0d other, %0d assertion; items sent %0d, in %0d, out %0d",
			mismatch_count, other_count, u_dut.u_sva.fail_count, sent, in_count, out_count);
		if (mismatch_count == 0 && other_count == 0 && u_dut.u_sva.fail_count == 0
			&& in_count == sent && out_count == sent) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== return_predictor.f ====
rv32i_types_pkg.sv
ras_pkg.sv
link_classifier.sv
return_stack.sv
next_pc_select.sv
return_predictor_top.sv
return_predictor_sva.sv
return_predictor_checker.sv
tb_return_predictor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the return predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_return_predictor \
	-f return_predictor.f

# error limit lets assertion failures reach the end of the run
./obj_dir/Vtb_return_predictor +verilator+error+limit+1000 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
else
	exit 1
fi
